// File: verilog/scadPkg.sv
////////////////////////////////////////
// Step count adder package
// Word types, mux selectors, ALU functions,
// sequencer states and the microword layout
////////////////////////////////////////

package scadPkg;

   // Step count adder word, SC, FE and result
   typedef logic [9:0]  scadWord_t;
   // Data path word, also the bus data width
   typedef logic [35:0] dpWord_t;
   // Bus word address
   typedef logic [7:0]  wbAdr_t;

   // A input selector
   typedef enum logic [2:0] {
      ASEL_SC    = 3'd0,
      ASEL_SNUM  = 3'd1,
      ASEL_PTR44 = 3'd2,
      ASEL_BYTE1 = 3'd3,
      ASEL_BYTE2 = 3'd4,
      ASEL_BYTE3 = 3'd5,
      ASEL_BYTE4 = 3'd6,
      ASEL_BYTE5 = 3'd7
   } aSel_e;

   // B input selector
   typedef enum logic [1:0] {
      BSEL_FE    = 2'd0,
      BSEL_EXP   = 2'd1,
      BSEL_SHIFT = 2'd2,
      BSEL_SIZE  = 2'd3
   } bSel_e;

   // ALU functions, encoding matches the microcode field
   typedef enum logic [2:0] {
      FUN_A_PLUS_A    = 3'd0,
      FUN_A_OR_B      = 3'd1,
      FUN_A_MINUS_B_1 = 3'd2,
      FUN_A_MINUS_B   = 3'd3,
      FUN_A_PLUS_B    = 3'd4,
      FUN_A_AND_B     = 3'd5,
      FUN_A_MINUS_1   = 3'd6,
      FUN_A           = 3'd7
   } scadFun_e;

   // Microsequencer states
   typedef enum logic [1:0] {
      SEQ_IDLE,
      SEQ_FETCH,
      SEQ_EXEC
   } seqState_e;

   // Microword, 27 bits, fun in the top bits
   typedef struct packed {
      scadFun_e   fun;
      aSel_e      aSel;
      bSel_e      bSel;
      scadWord_t  snum;
      logic       loadSc;
      logic       loadFe;
      logic       dispEn;
      logic       halt;
      // Next address
      logic [4:0] jump;
   } cromWord_t;

   // Register map above the control store window
   localparam wbAdr_t ADR_DP       = 8'h40;
   localparam wbAdr_t ADR_START    = 8'h41;
   localparam wbAdr_t ADR_STATUS   = 8'h42;
   localparam wbAdr_t ADR_READBACK = 8'h43;

endpackage

// File: verilog/scad.sv
////////////////////////////////////////
// Step count adder
// A and B input muxes, eight-function ALU,
// SC and FE registers and sign dispatch
////////////////////////////////////////

module scad
(
   input  logic               clk,
   input  logic               rst,
   input  logic               clken,
   input  scadPkg::cromWord_t cromWord,
   input  scadPkg::dpWord_t   dp,
   output scadPkg::scadWord_t result,
   output scadPkg::scadWord_t sc,
   output scadPkg::scadWord_t fe,
   output logic               dispScad
);

   import scadPkg::*;

   scadWord_t aIn;
   scadWord_t bIn;
   scadWord_t snum;

   assign snum = cromWord.snum;

   ////////////////////////////////////////
   // A input mux
   ////////////////////////////////////////

   // Byte fields take edge bits from snum or SC
   always_comb
   begin
      aIn = sc;
      case (cromWord.aSel)
         ASEL_SC:    aIn = sc;
         ASEL_SNUM:  aIn = snum;
         // Byte pointer with position 36
         ASEL_PTR44: aIn = {sc[9], 6'o44, dp[29], sc[1:0]};
         ASEL_BYTE1: aIn = {snum[9], dp[35:29], snum[1:0]};
         ASEL_BYTE2: aIn = {sc[9], dp[28:22], sc[1:0]};
         ASEL_BYTE3: aIn = {snum[9], dp[21:15], snum[1:0]};
         ASEL_BYTE4: aIn = {sc[9], dp[14:8], sc[1:0]};
         ASEL_BYTE5: aIn = {snum[9], dp[7:1], snum[1:0]};
      endcase
   end

   ////////////////////////////////////////
   // B input mux
   ////////////////////////////////////////

   always_comb
   begin
      bIn = fe;
      case (cromWord.bSel)
         BSEL_FE:    bIn = fe;
         // Exponent, ones complement for negative words
         BSEL_EXP:   bIn = {2'b00, dp[34:27] ^ {8{dp[35]}}};
         // Shift count, sign extended from bit 17
         BSEL_SHIFT: bIn = {dp[17], dp[17], dp[7:0]};
         // Byte size scaled by 8
         BSEL_SIZE:  bIn = {1'b0, dp[29:24], 3'b000};
      endcase
   end

   ////////////////////////////////////////
   // ALU
   ////////////////////////////////////////

   // Everything wraps at 10 bits
   always_comb
   begin
      result = aIn;
      case (cromWord.fun)
         FUN_A_PLUS_A:    result = aIn + aIn;
         FUN_A_OR_B:      result = aIn | bIn;
         FUN_A_MINUS_B_1: result = aIn - bIn - 10'd1;
         FUN_A_MINUS_B:   result = aIn - bIn;
         FUN_A_PLUS_B:    result = aIn + bIn;
         FUN_A_AND_B:     result = aIn & bIn;
         FUN_A_MINUS_1:   result = aIn - 10'd1;
         FUN_A:           result = aIn;
      endcase
   end

   // SC and FE load at the end of the execute cycle
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         sc <= '0;
         fe <= '0;
      end
      else if (clken)
      begin
         if (cromWord.loadSc)
            sc <= result;
         if (cromWord.loadFe)
            fe <= result;
      end
   end

   // Sign of the result for microcode branches
   assign dispScad = result[9];

   // Microword from the store must be clean when it executes
   aFieldsKnown : assert property (@(posedge clk) disable iff (rst)
      clken |-> !$isunknown({cromWord.fun, cromWord.aSel, cromWord.bSel}))
      else $error("scad: unknown function or selector during execute");

endmodule

// File: verilog/cromStore.sv
////////////////////////////////////////
// Writable control store
// Host write and read ports plus a
// registered microword fetch port
////////////////////////////////////////

module cromStore
#(
   parameter int addrWidth = 5
)
(
   input  logic                 clk,
   input  logic                 we,
   input  logic [addrWidth-1:0] wrAdr,
   input  scadPkg::cromWord_t   wrData,
   input  logic [addrWidth-1:0] rdAdr,
   input  logic [addrWidth-1:0] fetchAdr,
   output scadPkg::cromWord_t   rdData,
   output scadPkg::cromWord_t   cromWord
);

   import scadPkg::*;

   localparam int depth = 2 ** addrWidth;

   // Microcode array, contents undefined until loaded
   cromWord_t mem [depth];

   // Host write port
   always_ff @(posedge clk)
   begin
      if (we)
         mem[wrAdr] <= wrData;
   end

   // Host read port, combinational
   assign rdData = mem[rdAdr];

   // Fetch port
   // Address holds through execute so the word stays put
   always_ff @(posedge clk)
   begin
      cromWord <= mem[fetchAdr];
   end

endmodule

// File: verilog/microSeq.sv
////////////////////////////////////////
// Microsequencer
// Micro-PC, fetch and execute phases,
// jump with sign dispatch, halt to idle
////////////////////////////////////////

module microSeq
#(
   parameter int addrWidth = 5
)
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 start,
   input  logic [addrWidth-1:0] startAdr,
   input  scadPkg::cromWord_t   cromWord,
   input  logic                 dispScad,
   output logic [addrWidth-1:0] fetchAdr,
   output logic [addrWidth-1:0] upc,
   output logic                 clken,
   output logic                 running
);

   import scadPkg::*;

   seqState_e            state;
   logic [addrWidth-1:0] nextAdr;

   // Jump field, low bit ORed with the adder sign
   always_comb
   begin
      nextAdr = addrWidth'(cromWord.jump);
      nextAdr[0] = cromWord.jump[0] | (cromWord.dispEn & dispScad);
   end

   // Store is addressed straight from the micro-PC
   assign fetchAdr = upc;

   ////////////////////////////////////////
   // Sequencer FSM
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state   <= SEQ_IDLE;
         upc     <= '0;
         clken   <= 1'b0;
         running <= 1'b0;
      end
      else
      begin
         case (state)
            SEQ_IDLE:
            begin
               // Starts are only taken here
               if (start)
               begin
                  upc     <= startAdr;
                  running <= 1'b1;
                  state   <= SEQ_FETCH;
               end
            end
            SEQ_FETCH:
            begin
               // Store latches the word at this edge
               clken <= 1'b1;
               state <= SEQ_EXEC;
            end
            SEQ_EXEC:
            begin
               clken <= 1'b0;
               if (cromWord.halt)
               begin
                  // Micro-PC keeps the halt address
                  running <= 1'b0;
                  state   <= SEQ_IDLE;
               end
               else
               begin
                  upc   <= nextAdr;
                  state <= SEQ_FETCH;
               end
            end
            default:
            begin
               clken <= 1'b0;
               state <= SEQ_IDLE;
            end
         endcase
      end
   end

   // Slave passes starts only while the sequencer is idle
   aStartIdle : assert property (@(posedge clk) disable iff (rst)
      start |-> state == SEQ_IDLE)
      else $error("microSeq: start while a program runs");

endmodule

// File: verilog/wbSlave.sv
////////////////////////////////////////
// Wishbone classic slave
// Register map, dp operand register,
// start pulse and read data mux
////////////////////////////////////////

module wbSlave
#(
   parameter int addrWidth = 5
)
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 cyc,
   input  logic                 stb,
   input  logic                 we,
   input  scadPkg::wbAdr_t      adr,
   input  scadPkg::dpWord_t     datW,
   output scadPkg::dpWord_t     datR,
   output logic                 ack,
   input  logic                 running,
   input  logic [addrWidth-1:0] upc,
   input  scadPkg::scadWord_t   sc,
   input  scadPkg::scadWord_t   fe,
   input  scadPkg::scadWord_t   result,
   input  scadPkg::cromWord_t   cromRdData,
   output logic                 cromWe,
   output logic [addrWidth-1:0] cromAdr,
   output scadPkg::cromWord_t   cromWrData,
   output scadPkg::dpWord_t     dp,
   output logic                 start,
   output logic [addrWidth-1:0] startAdr
);

   import scadPkg::*;

   logic    req;
   logic    wrReq;
   logic    isCrom;
   dpWord_t rdMux;

   // New request, one idle cycle after each ack
   assign req    = cyc && stb && !ack;
   assign wrReq  = req && we;
   assign isCrom = (adr >> addrWidth) == '0;

   // Control store port
   assign cromAdr    = adr[addrWidth-1:0];
   assign cromWrData = cromWord_t'(datW[$bits(cromWord_t)-1:0]);
   // Store is locked while microcode runs
   assign cromWe     = wrReq && isCrom && !running;

   ////////////////////////////////////////
   // Read data mux
   ////////////////////////////////////////

   always_comb
   begin
      rdMux = '0;
      if (isCrom)
         rdMux = dpWord_t'(cromRdData);
      else if (adr == ADR_DP)
         rdMux = dp;
      else if (adr == ADR_STATUS)
         rdMux = dpWord_t'({upc, running});
      else if (adr == ADR_READBACK)
         rdMux = {6'b000000, result, fe, sc};
   end

   // Ack, dp register and start pulse
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         ack   <= 1'b0;
         dp    <= '0;
         start <= 1'b0;
      end
      else
      begin
         ack   <= req;
         start <= wrReq && adr == ADR_START && !running;
         if (wrReq && adr == ADR_DP)
            dp <= datW;
      end
   end

   // Read data and start address
   always_ff @(posedge clk)
   begin
      if (req)
         datR <= rdMux;
      if (wrReq && adr == ADR_START && !running)
         startAdr <= datW[addrWidth-1:0];
   end

   // Master keeps the strobe up through the ack cycle
   aAckInCycle : assert property (@(posedge clk) disable iff (rst)
      ack |-> cyc && stb)
      else $error("wbSlave: ack without an active cycle");

endmodule

// File: verilog/stepCountTop.sv
////////////////////////////////////////
// Step count subsystem top level
// Bus slave, control store, sequencer, adder
////////////////////////////////////////

module stepCountTop
#(
   parameter int addrWidth = 5
)
(
   input  logic             clk,
   input  logic             rst,
   input  logic             cyc,
   input  logic             stb,
   input  logic             we,
   input  scadPkg::wbAdr_t  adr,
   input  scadPkg::dpWord_t datW,
   output scadPkg::dpWord_t datR,
   output logic             ack
);

   import scadPkg::*;

   // Host side
   logic                 cromWe;
   logic [addrWidth-1:0] cromAdr;
   cromWord_t            cromWrData;
   cromWord_t            cromRdData;
   dpWord_t              dp;
   logic                 start;
   logic [addrWidth-1:0] startAdr;
   // Sequencer and adder
   logic [addrWidth-1:0] fetchAdr;
   logic [addrWidth-1:0] upc;
   logic                 clken;
   logic                 running;
   cromWord_t            cromWord;
   scadWord_t            result;
   scadWord_t            sc;
   scadWord_t            fe;
   logic                 dispScad;

   wbSlave #(.addrWidth(addrWidth)) u_wbSlave (
      .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we),
      .adr(adr), .datW(datW), .datR(datR), .ack(ack),
      .running(running), .upc(upc), .sc(sc), .fe(fe), .result(result),
      .cromRdData(cromRdData), .cromWe(cromWe), .cromAdr(cromAdr),
      .cromWrData(cromWrData), .dp(dp), .start(start), .startAdr(startAdr)
   );

   cromStore #(.addrWidth(addrWidth)) u_cromStore (
      .clk(clk), .we(cromWe), .wrAdr(cromAdr), .wrData(cromWrData),
      .rdAdr(cromAdr), .fetchAdr(fetchAdr), .rdData(cromRdData),
      .cromWord(cromWord)
   );

   microSeq #(.addrWidth(addrWidth)) u_microSeq (
      .clk(clk), .rst(rst), .start(start), .startAdr(startAdr),
      .cromWord(cromWord), .dispScad(dispScad), .fetchAdr(fetchAdr),
      .upc(upc), .clken(clken), .running(running)
   );

   scad u_scad (
      .clk(clk), .rst(rst), .clken(clken), .cromWord(cromWord), .dp(dp),
      .result(result), .sc(sc), .fe(fe), .dispScad(dispScad)
   );

endmodule

// File: sim/tbClock.sv
////////////////////////////////////////
// Testbench clock source
// Free running, 40 ns period
////////////////////////////////////////

module tbClock
(
   output logic clk
);

   timeunit 1ns;
   timeprecision 100ps;

   initial
      clk = 1'b0;

   // Half period of 20 ns
   always #20 clk = ~clk;

endmodule

// File: sim/stepCountTb.sv
////////////////////////////////////////
// Step count subsystem testbench
// Bus tasks, table of adder programs,
// countdown loop and store lock checks
////////////////////////////////////////

module stepCountTb;

   timeunit 1ns;
   timeprecision 100ps;

   import scadPkg::*;

   localparam int ackLimit  = 16;
   localparam int pollLimit = 200;

   // One table row, microword fields and SC/FE setup
   typedef struct packed {
      scadFun_e  fun;
      aSel_e     aSel;
      bSel_e     bSel;
      scadWord_t snum;
      scadWord_t scInit;
      scadWord_t feInit;
      logic      loadSc;
      logic      loadFe;
   } row_t;

   logic        clk;
   logic        rst;
   logic        cyc;
   logic        stb;
   logic        we;
   wbAdr_t      adr;
   dpWord_t     datW;
   dpWord_t     datR;
   logic        ack;
   int          errors;
   int          checks;
   logic [31:0] seed;
   row_t        rows [8];
   cromWord_t   stored [8];

   tbClock u_tbClock (.clk(clk));

   stepCountTop #(.addrWidth(5)) u_stepCountTop (
      .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we),
      .adr(adr), .datW(datW), .datR(datR), .ack(ack)
   );

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   // LCG, numerical recipes constants
   function automatic logic [31:0] nextRand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic cromWord_t buildWord(scadFun_e f, aSel_e a, bSel_e b,
      scadWord_t snum, logic ldSc, logic ldFe, logic disp, logic halt, logic [4:0] jump);
      return '{f, a, b, snum, ldSc, ldFe, disp, halt, jump};
   endfunction

   // Reference adder result from the selector and function rules
   function automatic scadWord_t scadModel(cromWord_t w, scadWord_t scV, scadWord_t feV,
      dpWord_t d);
      scadWord_t   a;
      scadWord_t   b;
      scadWord_t   edgeSrc;
      logic [7:0]  expo;
      int          k;
      int unsigned ai;
      int unsigned bi;
      int unsigned r;
      k = int'(w.aSel) - 3;
      if (w.aSel == ASEL_SC)
         a = scV;
      else if (w.aSel == ASEL_SNUM)
         a = w.snum;
      else if (w.aSel == ASEL_PTR44)
         a = {scV[9], 6'd36, d[29], scV[1:0]};
      else
      begin
         // Bytes 1, 3, 5 take edges from snum
         edgeSrc = (k % 2 == 0) ? w.snum : scV;
         a = {edgeSrc[9], 7'(d >> (29 - 7 * k)), edgeSrc[1:0]};
      end
      expo = d[35] ? ~d[34:27] : d[34:27];
      case (w.bSel)
         BSEL_FE:    b = feV;
         BSEL_EXP:   b = {2'b00, expo};
         BSEL_SHIFT: b = {{2{d[17]}}, d[7:0]};
         default:    b = {1'b0, d[29:24], 3'b000};
      endcase
      ai = a;
      bi = b;
      // Offsets by 1024 keep the subtractions positive
      case (w.fun)
         FUN_A_PLUS_A:    r = ai * 2;
         FUN_A_OR_B:      r = ai | bi;
         FUN_A_MINUS_B_1: r = ai + 2047 - bi;
         FUN_A_MINUS_B:   r = ai + 1024 - bi;
         FUN_A_PLUS_B:    r = ai + bi;
         FUN_A_AND_B:     r = ai & bi;
         FUN_A_MINUS_1:   r = ai + 1023;
         default:         r = ai;
      endcase
      return scadWord_t'(r % 1024);
   endfunction

   task automatic checkValue(input string what, input logic [35:0] got,
      input logic [35:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic reportAndFinish();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   endtask

   task automatic abortOnTimeout(input string why);
      errors++;
      $display("Timeout at %0t: %s", $time, why);
      reportAndFinish();
   endtask

   ////////////////////////////////////////
   // Bus tasks
   ////////////////////////////////////////

   // Strobe stays up through the ack cycle, dropped one edge later
   task automatic busCycle(input logic write, input wbAdr_t a, input dpWord_t d,
      output dpWord_t q);
      int waited;
      waited = 0;
      @(negedge clk);
      cyc  = 1'b1;
      stb  = 1'b1;
      we   = write;
      adr  = a;
      datW = d;
      @(negedge clk);
      while (!ack && waited < ackLimit)
      begin
         @(negedge clk);
         waited++;
      end
      if (!ack)
         abortOnTimeout("bus cycle was never acknowledged");
      else
      begin
         q = datR;
         @(negedge clk);
         cyc = 1'b0;
         stb = 1'b0;
         we  = 1'b0;
      end
   endtask

   task automatic wbWrite(input wbAdr_t a, input dpWord_t d);
      dpWord_t unused;
      busCycle(1'b1, a, d, unused);
   endtask

   task automatic wbRead(input wbAdr_t a, output dpWord_t q);
      busCycle(1'b0, a, '0, q);
   endtask

   task automatic writeWord(input wbAdr_t a, input cromWord_t w);
      wbWrite(a, {9'd0, w});
   endtask

   // Poll the running bit until the program halts
   task automatic waitHalt();
      dpWord_t st;
      int      polls;
      polls = 0;
      wbRead(ADR_STATUS, st);
      while (st[0] && polls < pollLimit)
      begin
         wbRead(ADR_STATUS, st);
         polls++;
      end
      if (st[0])
         abortOnTimeout("sequencer still running after the poll limit");
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial
   begin
      dpWord_t   rd;
      dpWord_t   dpVal;
      logic [31:0] hi;
      cromWord_t rowWord;
      row_t      row;
      scadWord_t r1;
      scadWord_t scExp;
      scadWord_t feExp;
      scadWord_t resExp;
      int        n;
      rst    = 1'b1;
      cyc    = 1'b0;
      stb    = 1'b0;
      we     = 1'b0;
      adr    = '0;
      datW   = '0;
      errors = 0;
      checks = 0;
      seed   = 32'h1c5aba20;
      n      = 5;
      // fun, aSel, bSel, snum, scInit, feInit, loadSc, loadFe
      rows[0] = '{FUN_A_PLUS_A,    ASEL_SC,    BSEL_FE,    10'h000, 10'h123, 10'h045, 1'b1, 1'b0};
      rows[1] = '{FUN_A_OR_B,      ASEL_SNUM,  BSEL_EXP,   10'h201, 10'h010, 10'h3F0, 1'b0, 1'b1};
      rows[2] = '{FUN_A_MINUS_B_1, ASEL_PTR44, BSEL_SHIFT, 10'h000, 10'h2A5, 10'h001, 1'b1, 1'b0};
      rows[3] = '{FUN_A_MINUS_B,   ASEL_BYTE1, BSEL_SIZE,  10'h203, 10'h000, 10'h100, 1'b1, 1'b1};
      rows[4] = '{FUN_A_PLUS_B,    ASEL_BYTE2, BSEL_FE,    10'h000, 10'h3FF, 10'h155, 1'b0, 1'b1};
      rows[5] = '{FUN_A_AND_B,     ASEL_BYTE3, BSEL_EXP,   10'h3FE, 10'h0F0, 10'h3FF, 1'b1, 1'b0};
      rows[6] = '{FUN_A_MINUS_1,   ASEL_BYTE4, BSEL_SHIFT, 10'h000, 10'h001, 10'h222, 1'b1, 1'b0};
      rows[7] = '{FUN_A,           ASEL_BYTE5, BSEL_SIZE,  10'h201, 10'h080, 10'h040, 1'b0, 1'b1};
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // Idle after reset
      wbRead(ADR_STATUS, rd);
      checkValue("status after reset", rd, '0);
      wbRead(ADR_READBACK, rd);
      checkValue("SC and FE after reset", {16'd0, rd[19:0]}, '0);

      // Store write and read back at 8..15
      for (int i = 0; i < 8; i++)
      begin
         stored[i] = cromWord_t'(27'(nextRand()));
         writeWord(wbAdr_t'(8 + i), stored[i]);
      end
      for (int i = 0; i < 8; i++)
      begin
         wbRead(wbAdr_t'(8 + i), rd);
         checkValue($sformatf("store word %0d", 8 + i), rd, {9'd0, stored[i]});
      end

      // Three words per row, setup FE, setup SC, then the row word with halt
      for (int i = 0; i < 8; i++)
      begin
         row = rows[i];
         rowWord = buildWord(row.fun, row.aSel, row.bSel, row.snum,
            row.loadSc, row.loadFe, 1'b0, 1'b1, 5'd0);
         writeWord(8'h00, buildWord(FUN_A, ASEL_SNUM, BSEL_FE, row.feInit,
            1'b0, 1'b1, 1'b0, 1'b0, 5'd1));
         writeWord(8'h01, buildWord(FUN_A, ASEL_SNUM, BSEL_FE, row.scInit,
            1'b1, 1'b0, 1'b0, 1'b0, 5'd2));
         writeWord(8'h02, rowWord);
         for (int p = 0; p < 3; p++)
         begin
            hi = nextRand();
            dpVal = {hi[3:0], nextRand()};
            wbWrite(ADR_DP, dpVal);
            wbWrite(ADR_START, 36'd0);
            waitHalt();
            r1 = scadModel(rowWord, row.scInit, row.feInit, dpVal);
            scExp = row.loadSc ? r1 : row.scInit;
            feExp = row.loadFe ? r1 : row.feInit;
            // Result readback sees the registers after the halt loads
            resExp = scadModel(rowWord, scExp, feExp, dpVal);
            wbRead(ADR_READBACK, rd);
            checkValue($sformatf("row %0d pass %0d readback", i, p), rd,
               {6'd0, resExp, feExp, scExp});
            wbRead(ADR_STATUS, rd);
            checkValue($sformatf("row %0d pass %0d status", i, p), rd, 36'd4);
         end
      end

      // Countdown from n, FE counts passes, exits at 21 on the sign
      writeWord(8'h10, buildWord(FUN_A, ASEL_SNUM, BSEL_FE, 10'd0,
         1'b0, 1'b1, 1'b0, 1'b0, 5'd17));
      writeWord(8'h11, buildWord(FUN_A, ASEL_SNUM, BSEL_FE, scadWord_t'(n),
         1'b1, 1'b0, 1'b0, 1'b0, 5'd18));
      writeWord(8'h12, buildWord(FUN_A_MINUS_1, ASEL_SC, BSEL_FE, 10'd0,
         1'b1, 1'b0, 1'b1, 1'b0, 5'd20));
      writeWord(8'h14, buildWord(FUN_A_PLUS_B, ASEL_SNUM, BSEL_FE, 10'd1,
         1'b0, 1'b1, 1'b0, 1'b0, 5'd18));
      writeWord(8'h15, buildWord(FUN_A_PLUS_B, ASEL_SNUM, BSEL_FE, 10'd1,
         1'b0, 1'b1, 1'b0, 1'b1, 5'd0));
      wbWrite(ADR_START, 36'd16);
      // Store is locked while the loop runs
      writeWord(8'h08, ~stored[0]);
      waitHalt();
      wbRead(8'h08, rd);
      checkValue("store word written while running", rd, {9'd0, stored[0]});
      wbRead(ADR_READBACK, rd);
      checkValue("countdown SC", {26'd0, rd[9:0]}, {26'd0, 10'h3FF});
      checkValue("countdown FE", {26'd0, rd[19:10]}, 36'(n + 1));
      wbRead(ADR_STATUS, rd);
      checkValue("halt address and running", rd, 36'd42);

      reportAndFinish();
   end

endmodule

// File: build.f
verilog/scadPkg.sv
verilog/scad.sv
verilog/cromStore.sv
verilog/microSeq.sv
verilog/wbSlave.sv
verilog/stepCountTop.sv
sim/tbClock.sv
sim/stepCountTb.sv

// File: Makefile
SRCS := $(wildcard verilog/*.sv sim/*.sv)

all: run

obj_dir/VstepCountTb: build.f $(SRCS)
	verilator --binary --timing --assert -j 0 -f build.f --top-module stepCountTb

run: obj_dir/VstepCountTb
	@out="$$(./obj_dir/VstepCountTb)"; echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

lint:
	verilator --lint-only --timing -Wall -f build.f --top-module stepCountTb

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
